//--- hw/rv_decode_pkg.sv
/*
 * RV32I decode stage package.
 * Widths, major opcodes, trap causes, the instruction word views
 * and the structs passed between fetch, decode and execute.
 */
`default_nettype none

package rv_decode_pkg;

    // --------------------------------------------------
    // Widths and constants
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES   = 32'd4;    // No compressed ops

    // --------------------------------------------------
    // Major opcodes
    // --------------------------------------------------
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0] TRAP_IACCESS = 7'd1;    // Instruction access fault
    localparam logic [6:0] TRAP_IOPCODE = 7'd2;    // Illegal instruction

    // --------------------------------------------------
    // Instruction word, one view per format
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } fmt_r_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } fmt_i_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } fmt_s_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } fmt_b_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } fmt_u_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } fmt_j_t;

    typedef union packed {
        fmt_r_t r;
        fmt_i_t i;
        fmt_s_t s;
        fmt_b_t b;
        fmt_u_t u;
        fmt_j_t j;
    } instr_u;

    // --------------------------------------------------
    // Stage structs
    // --------------------------------------------------
    typedef struct packed {
        instr_u     instr;
        logic [1:0] ferr;    // One bit per halfword
    } fetch_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic add, sub, and_op, or_op, xor_op, sll, srl, sra, slt, sltu;
    } alu_ops_t;

    typedef struct packed {
        logic beq, bne, blt, bge, bltu, bgeu, jal, jalr, ecall, ebrk, mret;
    } cfu_ops_t;

    typedef struct packed {
        logic load, store, byte_w, half_w, word_w, sext;
    } lsu_ops_t;

    typedef struct packed {
        logic alu, lsu, npc;
    } wb_sel_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       npc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       alu_lhs;
        logic [XLEN-1:0]       alu_rhs;
        alu_ops_t              alu;
        cfu_ops_t              cfu;
        lsu_ops_t              lsu;
        wb_sel_t               wb;
        logic                  trap;
        logic [6:0]            trap_cause;
    } decode_t;

endpackage

`default_nettype wire

//--- hw/rv_pc_track.sv
/*
 * Program counter tracking for the decode stage.
 * Loads the reset address, follows redirects and
 * steps by one instruction on each accept.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_track (
    input  logic                           g_clk,
    input  logic                           g_resetn,
    input  logic                           accept_i,      // Instruction leaves decode
    input  rv_decode_pkg::redirect_t       redirect_i,    // Control flow change
    output logic [rv_decode_pkg::XLEN-1:0] pc_o,
    output logic [rv_decode_pkg::XLEN-1:0] npc_o
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] pc_q;

    // --------------------------------------------------
    // PC register
    // --------------------------------------------------

    // Redirect wins over an accept in the same cycle
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;
        end else if (accept_i) begin
            pc_q <= npc_o;
        end
    end

    assign npc_o = pc_q + INSTR_BYTES;    // Always a 4 byte step
    assign pc_o  = pc_q;

endmodule

`default_nettype wire

//--- hw/rv_imm_decode.sv
/*
 * Immediate decoder.
 * Builds the I, S, B, U and J immediates and the shift amount,
 * then picks the one used by the current opcode.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_imm_decode (
    input  rv_decode_pkg::instr_u          instr_i,
    output logic [rv_decode_pkg::XLEN-1:0] imm_o
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;
    logic [6:0]      opcode;
    logic [2:0]      funct3;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;

    // --------------------------------------------------
    // Per format extraction
    // --------------------------------------------------
    assign imm_i = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_s = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
    assign imm_b = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u = {instr_i.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                    instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    // Low five bits of the I field, zero extended
    assign imm_shamt = {{(XLEN-5){1'b0}}, instr_i.i.imm_11_0[4:0]};

    // --------------------------------------------------
    // Format select
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            OPC_BRANCH: imm_o = imm_b;
            OPC_LUI,
            OPC_AUIPC:  imm_o = imm_u;
            OPC_JAL:    imm_o = imm_j;
            OPC_STORE:  imm_o = imm_s;
            OPC_OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_o = imm_shamt;    // Shift by immediate
                end else begin
                    imm_o = imm_i;
                end
            end
            OPC_LOAD,
            OPC_JALR:   imm_o = imm_i;
            default:    imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rv_op_decode.sv
/*
 * Opcode and function decoder.
 * Classifies RV32I words into ALU, control flow and load/store
 * micro-ops, register addresses, writeback select and traps.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_op_decode (
    input  rv_decode_pkg::instr_u                instr_i,
    input  logic [1:0]                           ferr_i,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_o,
    output rv_decode_pkg::alu_ops_t              alu_o,
    output rv_decode_pkg::cfu_ops_t              cfu_o,
    output rv_decode_pkg::lsu_ops_t              lsu_o,
    output rv_decode_pkg::wb_sel_t               wb_o,
    output logic                                 rhs_imm_o,       // Right operand is imm
    output logic                                 lhs_sel_pc_o,    // Left operand is PC
    output logic                                 lhs_zero_o,      // Left operand is zero
    output logic                                 trap_o,
    output logic [6:0]                           cause_o
);

    import rv_decode_pkg::*;

    logic [INSTR_W-1:0] word;
    logic [6:0]         opcode;
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic               f7_zero;
    logic               f7_alt;

    logic is_load, is_store, is_branch, is_op_imm, is_op;
    logic is_lui, is_auipc, is_jal, is_jalr, is_system;
    logic ld_ok, st_ok, br_ok, jalr_ok, alu_ok;
    logic is_ecall, is_ebrk, is_mret;
    logic fetch_err;
    logic invalid;

    assign word    = instr_i;
    assign opcode  = instr_i.r.opcode;
    assign f3      = instr_i.r.funct3;
    assign f7      = instr_i.r.funct7;
    assign f7_zero = (f7 == 7'b0000000);
    assign f7_alt  = (f7 == 7'b0100000);    // SUB and SRA(I)

    // --------------------------------------------------
    // Major opcode classes
    // --------------------------------------------------
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_op     = (opcode == OPC_OP);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);
    assign is_system = (opcode == OPC_SYSTEM);

    // Legal funct3/funct7 combinations per class
    assign ld_ok   = is_load && (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
    assign st_ok   = is_store && !f3[2] && (f3[1:0] != 2'b11);
    assign br_ok   = is_branch && (f3[2:1] != 2'b01);
    assign jalr_ok = is_jalr && (f3 == 3'b000);

    always_comb begin
        alu_ok = 1'b0;
        if (is_op) begin
            alu_ok = f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101));
        end else if (is_op_imm) begin
            case (f3)
                3'b001:  alu_ok = f7_zero;              // SLLI
                3'b101:  alu_ok = f7_zero || f7_alt;    // SRLI / SRAI
                default: alu_ok = 1'b1;
            endcase
        end
    end

    assign is_ecall = is_system && (word == 32'h0000_0073);
    assign is_ebrk  = is_system && (word == 32'h0010_0073);
    assign is_mret  = is_system && (word == 32'h3020_0073);

    // --------------------------------------------------
    // Register addresses
    // --------------------------------------------------
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_o       = (is_store || is_branch) ? '0 : instr_i.r.rd;

    // --------------------------------------------------
    // Micro-op flags
    // --------------------------------------------------
    assign alu_o.add    = (alu_ok && f3 == 3'b000 && !(is_op && f7_alt)) ||
                          is_auipc || ld_ok || st_ok;
    assign alu_o.sub    = (alu_ok && is_op && f7_alt && f3 == 3'b000) || br_ok;
    assign alu_o.and_op = alu_ok && (f3 == 3'b111);
    assign alu_o.or_op  = (alu_ok && f3 == 3'b110) || is_lui;    // LUI is 0 | imm
    assign alu_o.xor_op = alu_ok && (f3 == 3'b100);
    assign alu_o.sll    = alu_ok && (f3 == 3'b001);
    assign alu_o.srl    = alu_ok && (f3 == 3'b101) && !f7[5];
    assign alu_o.sra    = alu_ok && (f3 == 3'b101) && f7[5];
    assign alu_o.slt    = alu_ok && (f3 == 3'b010);
    assign alu_o.sltu   = alu_ok && (f3 == 3'b011);

    assign cfu_o.beq   = br_ok && (f3 == 3'b000);
    assign cfu_o.bne   = br_ok && (f3 == 3'b001);
    assign cfu_o.blt   = br_ok && (f3 == 3'b100);
    assign cfu_o.bge   = br_ok && (f3 == 3'b101);
    assign cfu_o.bltu  = br_ok && (f3 == 3'b110);
    assign cfu_o.bgeu  = br_ok && (f3 == 3'b111);
    assign cfu_o.jal   = is_jal;
    assign cfu_o.jalr  = jalr_ok;
    assign cfu_o.ecall = is_ecall;
    assign cfu_o.ebrk  = is_ebrk;
    assign cfu_o.mret  = is_mret;

    // A faulting fetch must never reach memory
    assign lsu_o.load   = ld_ok && !fetch_err;
    assign lsu_o.store  = st_ok && !fetch_err;
    assign lsu_o.byte_w = (ld_ok || st_ok) && (f3[1:0] == 2'b00);
    assign lsu_o.half_w = (ld_ok || st_ok) && (f3[1:0] == 2'b01);
    assign lsu_o.word_w = (ld_ok || st_ok) && (f3[1:0] == 2'b10);
    assign lsu_o.sext   = ld_ok && !f3[2];

    assign rhs_imm_o    = is_op_imm || is_lui || is_auipc || is_load || is_store;
    assign lhs_sel_pc_o = is_auipc;
    assign lhs_zero_o   = is_lui;

    // --------------------------------------------------
    // Traps and writeback select
    // --------------------------------------------------
    assign fetch_err = |ferr_i;
    assign invalid   = !(ld_ok || st_ok || br_ok || alu_ok || is_lui || is_auipc ||
                         is_jal || jalr_ok || is_ecall || is_ebrk || is_mret);

    assign trap_o  = fetch_err || invalid;
    assign cause_o = fetch_err ? TRAP_IACCESS :    // Fetch error has priority
                     invalid   ? TRAP_IOPCODE :
                                 7'd0;

    assign wb_o.npc = !trap_o && (cfu_o.jal || cfu_o.jalr);
    assign wb_o.lsu = !trap_o && lsu_o.load;
    assign wb_o.alu = !trap_o && !wb_o.npc && !is_branch && (|alu_o);

endmodule

`default_nettype wire

//--- hw/rv_decode_stage.sv
/*
 * RV32I decode and operand gather stage.
 * Tracks the PC, decodes the fetched word and gathers ALU
 * operands. Decode is combinational with a pass-through handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage (
    input  logic                                 g_clk,
    input  logic                                 g_resetn,
    input  rv_decode_pkg::fetch_t                fetch_i,
    input  logic                                 in_valid_i,
    output logic                                 in_ready_o,
    input  rv_decode_pkg::redirect_t             redirect_i,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_decode_pkg::XLEN-1:0]       rs1_data_i,    // Forwarded
    input  logic [rv_decode_pkg::XLEN-1:0]       rs2_data_i,    // Forwarded
    input  logic                                 out_ready_i,
    output logic                                 out_valid_o,
    output rv_decode_pkg::decode_t               dec_o
);

    import rv_decode_pkg::*;

    logic            accept;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] npc;
    logic [XLEN-1:0] imm;
    logic            rhs_imm;
    logic            lhs_sel_pc;
    logic            lhs_zero;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;
    assign accept      = in_valid_i && out_ready_i;

    rv_pc_track i_pc_track (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .accept_i   (accept),
        .redirect_i (redirect_i),
        .pc_o       (pc),
        .npc_o      (npc)
    );

    rv_imm_decode i_imm_decode (
        .instr_i (fetch_i.instr),
        .imm_o   (imm)
    );

    rv_op_decode i_op_decode (
        .instr_i      (fetch_i.instr),
        .ferr_i       (fetch_i.ferr),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .rd_o         (dec_o.rd),
        .alu_o        (dec_o.alu),
        .cfu_o        (dec_o.cfu),
        .lsu_o        (dec_o.lsu),
        .wb_o         (dec_o.wb),
        .rhs_imm_o    (rhs_imm),
        .lhs_sel_pc_o (lhs_sel_pc),
        .lhs_zero_o   (lhs_zero),
        .trap_o       (dec_o.trap),
        .cause_o      (dec_o.trap_cause)
    );

    // --------------------------------------------------
    // Operand gather
    // --------------------------------------------------
    assign dec_o.rs1_addr = rs1_addr_o;
    assign dec_o.rs2_addr = rs2_addr_o;
    assign dec_o.imm      = imm;
    assign dec_o.pc       = pc;
    assign dec_o.npc      = npc;
    assign dec_o.rs1_data = rs1_data_i;
    assign dec_o.rs2_data = rs2_data_i;

    assign dec_o.alu_lhs = lhs_sel_pc ? pc :    // AUIPC
                           lhs_zero   ? '0 :    // LUI
                                        rs1_data_i;
    assign dec_o.alu_rhs = rhs_imm ? imm : rs2_data_i;

endmodule

`default_nettype wire

//--- sim/tb_rv_decode_stage.sv
/*
 * Testbench for the RV32I decode stage.
 * Drives LCG generated instruction words through the handshake and
 * compares every valid cycle against a reference decode and PC model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode_stage;

    import rv_decode_pkg::*;

    logic                  g_clk;
    logic                  g_resetn;
    fetch_t                fetch_i;
    logic                  in_valid_i;
    logic                  in_ready_o;
    redirect_t             redirect_i;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    logic [XLEN-1:0]       rs1_data_i;
    logic [XLEN-1:0]       rs2_data_i;
    logic                  out_ready_i;
    logic                  out_valid_o;
    decode_t               dec_o;

    logic [31:0]     seed;
    logic [XLEN-1:0] pc_model;
    logic            timed_out;
    int              checks;
    int              errors;

    rv_decode_stage i_dut (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .fetch_i     (fetch_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .redirect_i  (redirect_i),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .dec_o       (dec_o)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;    // 4 ns period
    end

    // --------------------------------------------------
    // Random numbers
    // --------------------------------------------------
    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int pick(input int n);
        logic [31:0] r;
        r = rand32();
        return int'(r[31:16]) % n;    // Upper bits have the longer period
    endfunction

    // Kind 0 is OP, 1 OP-IMM, 2 LUI, 3 AUIPC, 4 LOAD, 5 STORE,
    // 6 BRANCH, 7 JAL, 8 JALR, 9 SYSTEM, 10 unknown opcode
    function automatic logic [31:0] make_word(input int kind);
        logic [31:0] w;
        logic [2:0]  f3;
        int          p;
        w  = rand32();
        f3 = w[14:12];
        p  = pick(6);
        case (kind)
            0: begin
                w[6:0]   = OPC_OP;
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && p < 3) ? 7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = OPC_OP_IMM;
                if (f3 == 3'd1) w[31:25] = 7'h00;
                if (f3 == 3'd5) w[31:25] = (p < 3) ? 7'h20 : 7'h00;
            end
            2: w[6:0] = OPC_LUI;
            3: w[6:0] = OPC_AUIPC;
            4: begin
                w[6:0]   = OPC_LOAD;
                w[14:12] = (p % 5 < 3) ? 3'(p % 5) : 3'(p % 5 + 1);    // LB..LW, LBU, LHU
            end
            5: begin
                w[6:0]   = OPC_STORE;
                w[14:12] = 3'(p % 3);
            end
            6: begin
                w[6:0]   = OPC_BRANCH;
                w[14:12] = (p < 2) ? 3'(p) : 3'(p + 2);
            end
            7: w[6:0] = OPC_JAL;
            8: begin
                w[6:0]   = OPC_JALR;
                w[14:12] = 3'd0;
            end
            9: begin
                case (p % 4)
                    0: w = 32'h0000_0073;    // ECALL
                    1: w = 32'h0010_0073;    // EBREAK
                    2: w = 32'h3020_0073;    // MRET
                    default: w[6:0] = OPC_SYSTEM;
                endcase
            end
            default: begin
                if (p < 3) w[1:0] = 2'b00;    // Every major opcode ends in 11
                else w[6:0] = 7'h0b;
            end
        endcase
        return w;
    endfunction

    function automatic int kind_for_test(input int id);
        case (id)
            2: return 1 + pick(8);
            3: return pick(4);
            4: return 4 + pick(5);
            5: return 4 + pick(7);
            default: return pick(10);
        endcase
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "pc tracking";
            2: return "immediates";
            3: return "alu operands";
            4: return "memory and control flow";
            5: return "traps";
            default: return "redirect";
        endcase
    endfunction

    // --------------------------------------------------
    // Reference decode
    // --------------------------------------------------
    function automatic alu_ops_t alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_ops_t a;
        a = '0;
        case (f3)
            3'd0: begin
                a.add = !alt;
                a.sub = alt;
            end
            3'd1: a.sll = 1'b1;
            3'd2: a.slt = 1'b1;
            3'd3: a.sltu = 1'b1;
            3'd4: a.xor_op = 1'b1;
            3'd5: begin
                a.srl = !alt;
                a.sra = alt;
            end
            3'd6: a.or_op = 1'b1;
            default: a.and_op = 1'b1;
        endcase
        return a;
    endfunction

    function automatic decode_t ref_decode(input logic [31:0] w, input logic [1:0] ferr,
                                           input logic [31:0] pc, input logic [31:0] a,
                                           input logic [31:0] b);
        decode_t     d;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic        legal;
        logic        rhs_imm;
        logic        mem_ok;
        d        = '0;
        f3       = w[14:12];
        f7       = w[31:25];
        imm_i    = {{20{w[31]}}, w[31:20]};
        legal    = 1'b0;
        rhs_imm  = 1'b0;
        mem_ok   = 1'b0;
        d.rs1_addr = w[19:15];
        d.rs2_addr = w[24:20];
        d.rd       = w[11:7];
        d.pc       = pc;
        d.npc      = pc + 32'd4;
        d.rs1_data = a;
        d.rs2_data = b;
        d.alu_lhs  = a;
        case (w[6:0])
            OPC_OP: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                if (legal) d.alu = alu_from_funct(f3, f7 == 7'h20);
            end
            OPC_OP_IMM: begin
                rhs_imm = 1'b1;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    d.imm = {27'b0, w[24:20]};    // Shift amount
                    legal = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
                end else begin
                    d.imm = imm_i;
                    legal = 1'b1;
                end
                if (legal) d.alu = alu_from_funct(f3, f3 == 3'd5 && f7[5]);
            end
            OPC_LUI, OPC_AUIPC: begin
                rhs_imm = 1'b1;
                legal   = 1'b1;
                d.imm   = {w[31:12], 12'b0};
                d.alu.or_op = (w[6:0] == OPC_LUI);
                d.alu.add   = (w[6:0] == OPC_AUIPC);
                d.alu_lhs   = (w[6:0] == OPC_LUI) ? 32'd0 : pc;
            end
            OPC_LOAD, OPC_STORE: begin
                rhs_imm = 1'b1;
                if (w[6:0] == OPC_LOAD) begin
                    d.imm  = imm_i;
                    legal  = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
                    d.lsu.load = legal;
                    d.lsu.sext = legal && !f3[2];
                end else begin
                    d.rd   = '0;
                    d.imm  = {{20{w[31]}}, w[31:25], w[11:7]};
                    legal  = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2);
                    d.lsu.store = legal;
                end
                d.alu.add    = legal;
                d.lsu.byte_w = legal && (f3[1:0] == 2'd0);
                d.lsu.half_w = legal && (f3[1:0] == 2'd1);
                d.lsu.word_w = legal && (f3[1:0] == 2'd2);
            end
            OPC_BRANCH: begin
                d.rd  = '0;
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                legal = (f3 != 3'd2) && (f3 != 3'd3);
                d.alu.sub  = legal;    // Compare by subtract
                d.cfu.beq  = (f3 == 3'd0);
                d.cfu.bne  = (f3 == 3'd1);
                d.cfu.blt  = (f3 == 3'd4);
                d.cfu.bge  = (f3 == 3'd5);
                d.cfu.bltu = (f3 == 3'd6);
                d.cfu.bgeu = (f3 == 3'd7);
            end
            OPC_JAL: begin
                legal = 1'b1;
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                d.cfu.jal = 1'b1;
            end
            OPC_JALR: begin
                d.imm  = imm_i;
                legal  = (f3 == 3'd0);
                d.cfu.jalr = legal;
            end
            OPC_SYSTEM: begin
                d.cfu.ecall = (w == 32'h0000_0073);
                d.cfu.ebrk  = (w == 32'h0010_0073);
                d.cfu.mret  = (w == 32'h3020_0073);
                legal = d.cfu.ecall || d.cfu.ebrk || d.cfu.mret;
            end
            default: legal = 1'b0;
        endcase
        d.alu_rhs = rhs_imm ? d.imm : b;
        if (ferr != 2'b00) begin
            d.trap       = 1'b1;
            d.trap_cause = TRAP_IACCESS;
            d.lsu.load   = 1'b0;
            d.lsu.store  = 1'b0;
        end else if (!legal) begin
            d.trap       = 1'b1;
            d.trap_cause = TRAP_IOPCODE;
        end
        if (!d.trap) begin
            d.wb.npc = d.cfu.jal || d.cfu.jalr;
            d.wb.lsu = d.lsu.load;
            d.wb.alu = !d.wb.npc && (w[6:0] != OPC_BRANCH) && (|d.alu);
        end
        return d;
    endfunction

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // PC model where a redirect wins over an accept
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_model <= PC_RESET_ADDR;
        end else if (redirect_i.valid) begin
            pc_model <= redirect_i.target;
        end else if (in_valid_i && out_ready_i) begin
            pc_model <= pc_model + 32'd4;
        end
    end

    always @(negedge g_clk) begin
        decode_t exp;
        if (g_resetn) begin
            check_value("in_ready_o", in_ready_o, out_ready_i);
            check_value("out_valid_o", out_valid_o, in_valid_i);
            if (out_valid_o) begin
                exp = ref_decode(fetch_i.instr, fetch_i.ferr, pc_model, rs1_data_i, rs2_data_i);
                check_value("rs1_addr_o", rs1_addr_o, exp.rs1_addr);
                check_value("rs2_addr_o", rs2_addr_o, exp.rs2_addr);
                check_value("dec_o.rs1_addr", dec_o.rs1_addr, exp.rs1_addr);
                check_value("dec_o.rs2_addr", dec_o.rs2_addr, exp.rs2_addr);
                check_value("dec_o.rd", dec_o.rd, exp.rd);
                check_value("dec_o.imm", dec_o.imm, exp.imm);
                check_value("dec_o.pc", dec_o.pc, exp.pc);
                check_value("dec_o.npc", dec_o.npc, exp.npc);
                check_value("dec_o.rs1_data", dec_o.rs1_data, exp.rs1_data);
                check_value("dec_o.rs2_data", dec_o.rs2_data, exp.rs2_data);
                check_value("dec_o.alu_lhs", dec_o.alu_lhs, exp.alu_lhs);
                check_value("dec_o.alu_rhs", dec_o.alu_rhs, exp.alu_rhs);
                check_value("dec_o.alu", dec_o.alu, exp.alu);
                check_value("dec_o.cfu", dec_o.cfu, exp.cfu);
                check_value("dec_o.lsu", dec_o.lsu, exp.lsu);
                check_value("dec_o.wb", dec_o.wb, exp.wb);
                check_value("dec_o.trap", dec_o.trap, exp.trap);
                check_value("dec_o.trap_cause", dec_o.trap_cause, exp.trap_cause);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic drive_idle();
        in_valid_i  <= 1'b0;
        out_ready_i <= (pick(2) == 1);    // Ready without valid is no accept
        redirect_i  <= '0;
        @(posedge g_clk);
    endtask

    // Holds the word until the DUT reports it ready
    task automatic send_word(input logic [31:0] word, input logic [1:0] ferr,
                             input logic redir);
        int          waited;
        logic        taken;
        logic [31:0] tgt;
        waited = 0;
        taken  = 1'b0;
        tgt    = rand32() & 32'hffff_fffc;
        while (!taken && !timed_out) begin
            fetch_i.instr     <= word;
            fetch_i.ferr      <= ferr;
            in_valid_i        <= 1'b1;
            out_ready_i       <= redir || (pick(4) != 0);    // Redirect cycle also accepts
            rs1_data_i        <= rand32();
            rs2_data_i        <= rand32();
            redirect_i.valid  <= redir && (waited == 0);
            redirect_i.target <= tgt;
            @(posedge g_clk);
            taken = (in_ready_o === 1'b1);    // Ready seen at this edge
            waited++;
            if (!taken && waited >= 64) begin
                $display("timeout: word %h was not accepted within %0d cycles",
                         word, waited);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int id);
        int         n;
        int         kind;
        logic [1:0] ferr;
        logic       redir;
        for (n = 0; n < 150 && !timed_out; n++) begin
            kind  = kind_for_test(id);
            ferr  = (id == 5 && pick(2) == 0) ? 2'(1 + pick(3)) : 2'b00;
            redir = (id == 6) && (pick(3) == 0);
            if (id == 1 && pick(4) == 0) drive_idle();
            send_word(make_word(kind), ferr, redir);
        end
    endtask

    initial begin
        int id;
        int checks_before;
        int errors_before;
        seed        = 32'h0e93_c0aa;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        g_resetn    = 1'b0;
        fetch_i     = '0;
        in_valid_i  = 1'b0;
        redirect_i  = '0;
        rs1_data_i  = '0;
        rs2_data_i  = '0;
        out_ready_i = 1'b0;
        repeat (4) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (id = 1; id <= 6 && !timed_out; id++) begin
            checks_before = checks;
            errors_before = errors;
            if (id == 1) begin
                @(negedge g_clk);
                check_value("dec_o.pc after reset", dec_o.pc, PC_RESET_ADDR);
                @(posedge g_clk);
            end
            run_test(id);
            $display("test %0d %s: %0d checks, %0d errors", id, test_name(id),
                     checks - checks_before, errors - errors_before);
        end
        $display("total: %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
        if (!timed_out && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/rv_decode_pkg.sv
hw/rv_pc_track.sv
hw/rv_imm_decode.sv
hw/rv_op_decode.sv
hw/rv_decode_stage.sv
sim/tb_rv_decode_stage.sv
